// ==== verilog/rmii_rx_pkg.sv ====
package rmii_rx_pkg;

    //////////////////////////////
    // RMII framing
    //////////////////////////////
    localparam int DIBIT_W         = 2;
    localparam int BYTE_W          = 8;
    localparam int DIBITS_PER_BYTE = BYTE_W / DIBIT_W;

    // 0x55 and 0xd5 seen one dibit at a time, LSB first
    localparam logic [DIBIT_W-1:0] PREAMBLE_DIBIT = 2'b01;
    localparam logic [DIBIT_W-1:0] SFD_DIBIT      = 2'b11;

    //////////////////////////////
    // Frame buffer
    //////////////////////////////
    localparam int FIFO_DEPTH  = 64;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    //////////////////////////////
    // CRC-32, reflected form
    //////////////////////////////
    localparam int               CRC_W       = 32;
    localparam logic [CRC_W-1:0] CRC_POLY    = 32'hedb8_8320;
    localparam logic [CRC_W-1:0] CRC_INIT    = 32'hffff_ffff;
    // Left in the register once a good FCS has gone through
    localparam logic [CRC_W-1:0] CRC_RESIDUE = 32'hdebb_20e3;

    typedef struct packed {
        logic              error;
        logic              last;
        logic [BYTE_W-1:0] data;
    } frame_word_t;

endpackage

// ==== verilog/rmii_rx_deserializer.sv ====
module rmii_rx_deserializer
    import rmii_rx_pkg::*;
(
    input  logic               clock,
    input  logic               rst_n,
    input  logic [DIBIT_W-1:0] rmii_receive_data,
    input  logic               rmii_receive_data_enable,
    input  logic               rmii_receive_data_error,
    output frame_word_t        wr_word,
    output logic               wr_en
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HUNT,
        ST_COLLECT,
        ST_FLUSH
    } state_t;

    state_t                             state;
    logic [$clog2(DIBITS_PER_BYTE)-1:0] dibit_cnt;
    logic [BYTE_W-1:0]                  shift_q;
    logic                               err_acc;
    logic [BYTE_W-1:0]                  next_byte;
    logic                               next_err;
    logic                               byte_done;
    logic [BYTE_W-1:0]                  held_data;
    logic                               held_err;
    logic                               held_valid;

    // First dibit ends up in the low bits
    assign next_byte = {rmii_receive_data, shift_q[BYTE_W-1:DIBIT_W]};
    assign next_err  = err_acc | rmii_receive_data_error;
    assign byte_done = (state == ST_COLLECT) && rmii_receive_data_enable &&
                       (int'(dibit_cnt) == DIBITS_PER_BYTE - 1);

    //////////////////////////////
    // Control
    //////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            dibit_cnt  <= '0;
            err_acc    <= 1'b0;
            held_valid <= 1'b0;
            wr_en      <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (rmii_receive_data_enable && rmii_receive_data == PREAMBLE_DIBIT) begin
                        state <= ST_HUNT;
                    end
                end
                ST_HUNT: begin
                    dibit_cnt  <= '0;
                    err_acc    <= 1'b0;
                    held_valid <= 1'b0;
                    if (!rmii_receive_data_enable) begin
                        state <= ST_IDLE;
                    end else if (rmii_receive_data == SFD_DIBIT) begin
                        state <= ST_COLLECT;
                    end else if (rmii_receive_data != PREAMBLE_DIBIT) begin
                        state <= ST_IDLE;
                    end
                end
                ST_COLLECT: begin
                    if (!rmii_receive_data_enable) begin
                        state <= ST_FLUSH;
                    end else begin
                        dibit_cnt <= dibit_cnt + 1'b1;
                        err_acc   <= byte_done ? 1'b0 : next_err;
                        // Previous byte goes out once the next one is complete
                        if (byte_done) begin
                            wr_en      <= held_valid;
                            held_valid <= 1'b1;
                        end
                    end
                end
                ST_FLUSH: begin
                    wr_en      <= held_valid;
                    held_valid <= 1'b0;
                    state      <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Byte assembly
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (state == ST_COLLECT && rmii_receive_data_enable) begin
            shift_q <= next_byte;
        end
        if (byte_done) begin
            held_data <= next_byte;
            held_err  <= next_err;
        end
        if (byte_done || state == ST_FLUSH) begin
            wr_word.data  <= held_data;
            wr_word.error <= held_err;
            wr_word.last  <= (state == ST_FLUSH);
        end
    end

endmodule

// ==== verilog/frame_fifo.sv ====
module frame_fifo
    import rmii_rx_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  frame_word_t wr_word,
    input  logic        wr_en,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    output frame_word_t wb_dat,
    output logic        wb_ack
);

    frame_word_t          mem [FIFO_DEPTH];
    logic [FIFO_ADDR_W:0] wr_ptr;
    logic [FIFO_ADDR_W:0] rd_ptr;
    logic                 empty;
    logic                 full;
    logic                 push;

    // Extra pointer bit tells a full buffer from an empty one
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
                   (wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);

    // Overflow drops the word
    assign push = wr_en && !full;

    //////////////////////////////
    // Wishbone read slave
    //////////////////////////////
    // Head word always on the bus
    assign wb_dat = mem[rd_ptr[FIFO_ADDR_W-1:0]];
    assign wb_ack = wb_cyc && wb_stb && !wb_we && !empty;

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= wr_word;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // Pop on the acknowledging edge
            if (wb_ack) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/frame_checker.sv ====
module frame_checker
    import rmii_rx_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  frame_word_t wb_dat,
    input  logic        wb_ack,
    input  logic        receive_data_enable,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output frame_word_t receive_data,
    output logic        receive_data_valid,
    output logic        receive_frame_good
);

    logic             fetch_q;
    logic             take;
    logic             load;
    logic [CRC_W-1:0] crc_q;
    logic [CRC_W-1:0] crc_next;
    logic             frame_err;
    logic             err_next;

    // One byte through the reflected CRC, LSB first
    function automatic logic [CRC_W-1:0] crc_byte(input logic [CRC_W-1:0] crc_in,
                                                  input logic [BYTE_W-1:0] data);
        logic [CRC_W-1:0] c;
        c = crc_in ^ {{(CRC_W - BYTE_W){1'b0}}, data};
        for (int i = 0; i < BYTE_W; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    assign take = receive_data_valid && receive_data_enable;

    //////////////////////////////
    // Wishbone read master
    //////////////////////////////
    // Strobe while the output register is free or leaving this cycle
    assign wb_stb = fetch_q || take;
    assign wb_cyc = wb_stb;
    assign wb_we  = 1'b0;
    assign load   = wb_stb && wb_ack;

    assign crc_next = crc_byte(crc_q, wb_dat.data);
    assign err_next = frame_err || wb_dat.error;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            receive_data_valid <= 1'b0;
            receive_frame_good <= 1'b0;
            fetch_q            <= 1'b0;
            crc_q              <= CRC_INIT;
            frame_err          <= 1'b0;
        end else begin
            if (load) begin
                receive_data_valid <= 1'b1;
                if (wb_dat.last) begin
                    receive_frame_good <= (crc_next == CRC_RESIDUE) && !err_next;
                    crc_q              <= CRC_INIT;
                    frame_err          <= 1'b0;
                end else begin
                    receive_frame_good <= 1'b0;
                    crc_q              <= crc_next;
                    frame_err          <= err_next;
                end
            end else if (take) begin
                receive_data_valid <= 1'b0;
            end
            // Request again whenever the register ends up empty
            fetch_q <= !(load || (receive_data_valid && !take));
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            receive_data <= wb_dat;
        end
    end

endmodule

// ==== verilog/rmii_rx_port.sv ====
module rmii_rx_port
    import rmii_rx_pkg::*;
(
    input  logic               clock,
    input  logic               rst_n,
    input  logic [DIBIT_W-1:0] rmii_receive_data,
    input  logic               rmii_receive_data_enable,
    input  logic               rmii_receive_data_error,
    input  logic               receive_data_enable,
    output frame_word_t        receive_data,
    output logic               receive_data_valid,
    output logic               receive_frame_good
);

    // Deserializer into buffer
    frame_word_t wr_word;
    logic        wr_en;

    // Wishbone between buffer and checker
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    frame_word_t wb_dat;
    logic        wb_ack;

    rmii_rx_deserializer rmii_rx_deserializer (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .wr_word                  (wr_word),
        .wr_en                    (wr_en)
    );

    frame_fifo frame_fifo (
        .clock   (clock),
        .rst_n   (rst_n),
        .wr_word (wr_word),
        .wr_en   (wr_en),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_dat  (wb_dat),
        .wb_ack  (wb_ack)
    );

    frame_checker frame_checker (
        .clock               (clock),
        .rst_n               (rst_n),
        .wb_dat              (wb_dat),
        .wb_ack              (wb_ack),
        .receive_data_enable (receive_data_enable),
        .wb_cyc              (wb_cyc),
        .wb_stb              (wb_stb),
        .wb_we               (wb_we),
        .receive_data        (receive_data),
        .receive_data_valid  (receive_data_valid),
        .receive_frame_good  (receive_frame_good)
    );

endmodule

// ==== dv/rmii_rx_port_sva.sv ====
module rmii_rx_port_sva
    import rmii_rx_pkg::*;
(
    input logic        clock,
    input logic        rst_n,
    input logic        wb_stb,
    input logic        wb_ack,
    input logic        receive_data_enable,
    input frame_word_t receive_data,
    input logic        receive_data_valid,
    input logic        receive_frame_good
);

    //////////////////////////////
    // Wishbone read handshake
    //////////////////////////////
    stb_held: assert property (@(posedge clock) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb)
        else $error("wb_stb dropped before wb_ack");

    // A transfer never lands on a word the outside still holds
    no_overwrite: assert property (@(posedge clock) disable iff (!rst_n)
        wb_ack |-> !receive_data_valid || receive_data_enable)
        else $error("wb_ack while the output word was still stalled");

    //////////////////////////////
    // Output hold under back-pressure
    //////////////////////////////
    output_hold: assert property (@(posedge clock) disable iff (!rst_n)
        receive_data_valid && !receive_data_enable |=>
            receive_data_valid && $stable(receive_data) && $stable(receive_frame_good))
        else $error("output word changed while stalled");

endmodule

bind rmii_rx_port rmii_rx_port_sva sva (
    .clock               (clock),
    .rst_n               (rst_n),
    .wb_stb              (wb_stb),
    .wb_ack              (wb_ack),
    .receive_data_enable (receive_data_enable),
    .receive_data        (receive_data),
    .receive_data_valid  (receive_data_valid),
    .receive_frame_good  (receive_frame_good)
);

// ==== dv/rmii_rx_port_tb.sv ====
module rmii_rx_port_tb
    import rmii_rx_pkg::*;
();

    logic               clock;
    logic               rst_n;
    logic [DIBIT_W-1:0] rmii_receive_data;
    logic               rmii_receive_data_enable;
    logic               rmii_receive_data_error;
    logic               receive_data_enable;
    frame_word_t        receive_data;
    logic               receive_data_valid;
    logic               receive_frame_good;

    // Frames as read from the stimulus file
    logic [BYTE_W-1:0] frame_bytes [$];
    int                frame_start [$];
    int                frame_len [$];
    int                frame_err_idx [$];
    bit                frame_stray [$];
    bit                frame_good [$];
    int                frame_idle [$];

    integer seed = 32'hf28d_ad41;
    int     err_data;
    int     err_good;
    int     err_valid;
    int     err_other;
    bit     first_data_sent;
    bit     aborted;

    rmii_rx_port uut (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .receive_data_enable      (receive_data_enable),
        .receive_data             (receive_data),
        .receive_data_valid       (receive_data_valid),
        .receive_frame_good       (receive_frame_good)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    //////////////////////////////
    // Stimulus file
    //////////////////////////////
    function automatic int hex_value(input int c);
        if (c >= 48 && c <= 57) begin
            return c - 48;
        end else if (c >= 97 && c <= 102) begin
            return c - 87;
        end else if (c >= 65 && c <= 70) begin
            return c - 55;
        end
        return -1;
    endfunction

    task automatic load_stimulus();
        int    fd;
        string line;
        int    vals [$];
        int    i;
        int    k;
        int    c;
        int    digit;
        int    acc;
        bit    in_tok;
        bit    in_comment;
        fd = $fopen("dv/rmii_rx_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/rmii_rx_stimulus.txt");
            err_other++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            vals.delete();
            acc        = 0;
            in_tok     = 1'b0;
            in_comment = 1'b0;
            for (i = 0; i < line.len(); i++) begin
                c     = int'(line[i]);
                digit = hex_value(c);
                if (!in_comment && digit >= 0) begin
                    acc    = acc * 16 + digit;
                    in_tok = 1'b1;
                end else begin
                    if (in_tok) begin
                        vals.push_back(acc);
                    end
                    acc    = 0;
                    in_tok = 1'b0;
                    // '#' starts a comment
                    if (c == 35) begin
                        in_comment = 1'b1;
                    end
                end
            end
            if (in_tok) begin
                vals.push_back(acc);
            end
            if (vals.size() > 0 && vals.size() < 5) begin
                $display("Stimulus line has too few fields: %s", line);
                err_other++;
            end else if (vals.size() >= 5) begin
                frame_err_idx.push_back(vals[0]);
                frame_stray.push_back(vals[1] != 0);
                frame_good.push_back(vals[2] != 0);
                frame_idle.push_back(vals[3]);
                frame_start.push_back(frame_bytes.size());
                frame_len.push_back(vals.size() - 4);
                for (k = 4; k < vals.size(); k++) begin
                    frame_bytes.push_back(vals[k][BYTE_W-1:0]);
                end
            end
        end
        $fclose(fd);
        $display("Loaded %0d frames", frame_len.size());
    endtask

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_word(input int f, input int i, input frame_word_t exp,
                              input frame_word_t act);
        if (act !== exp) begin
            $display("ERR receive_data exp 0x%03h act 0x%03h (frame %0d byte %0d)",
                     exp, act, f, i);
            err_data++;
        end
    endtask

    task automatic check_good(input int f, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR receive_frame_good exp 0x%0h act 0x%0h (frame %0d)", exp, act, f);
            err_good++;
        end
    endtask

    task automatic check_idle(input logic act, input string where);
        if (act !== 1'b0) begin
            $display("ERR receive_data_valid exp 0x0 act 0x%0h (%s)", act, where);
            err_valid++;
        end
    endtask

    //////////////////////////////
    // RMII driver
    //////////////////////////////
    task automatic send_dibit(input logic [DIBIT_W-1:0] d, input logic en, input logic err);
        @(posedge clock);
        #1;
        rmii_receive_data        = d;
        rmii_receive_data_enable = en;
        rmii_receive_data_error  = err;
    endtask

    // LSB dibit first, error raised on the second dibit only
    task automatic send_byte(input logic [BYTE_W-1:0] b, input logic err);
        int j;
        for (j = 0; j < DIBITS_PER_BYTE; j++) begin
            send_dibit(b[j*DIBIT_W +: DIBIT_W], 1'b1, err && (j == 1));
        end
    endtask

    task automatic send_frame(input int f);
        int i;
        repeat (7) send_byte(8'h55, 1'b0);
        send_byte(8'hd5, 1'b0);
        for (i = 0; i < frame_len[f]; i++) begin
            send_byte(frame_bytes[frame_start[f] + i], i == frame_err_idx[f]);
            first_data_sent = 1'b1;
        end
        if (frame_stray[f]) begin
            send_dibit(2'b10, 1'b1, 1'b0);
        end
        repeat (frame_idle[f]) send_dibit(2'b00, 1'b0, 1'b0);
    endtask

    task automatic drive_frames();
        int f;
        repeat (4) send_dibit(2'b00, 1'b0, 1'b0);
        for (f = 0; f < frame_len.size(); f++) begin
            send_frame(f);
        end
    endtask

    //////////////////////////////
    // Output monitor
    //////////////////////////////
    task automatic monitor_frames();
        int          f;
        int          i;
        int          waited;
        bit          got;
        frame_word_t exp;
        frame_word_t act;
        logic        act_good;
        waited = 0;
        // Nothing may come out before the first data byte
        while (!first_data_sent && waited < 500) begin
            @(negedge clock);
            check_idle(receive_data_valid, "before the first frame");
            waited++;
        end
        if (!first_data_sent) begin
            $display("The driver never reached the first data byte");
            err_other++;
            aborted = 1'b1;
        end
        for (f = 0; f < frame_len.size() && !aborted; f++) begin
            for (i = 0; i < frame_len[f] && !aborted; i++) begin
                exp.data  = frame_bytes[frame_start[f] + i];
                exp.last  = (i == frame_len[f] - 1);
                exp.error = (i == frame_err_idx[f]);
                got       = 1'b0;
                waited    = 0;
                while (!got && waited < 2000) begin
                    @(negedge clock);
                    if (receive_data_valid && receive_data_enable) begin
                        got      = 1'b1;
                        act      = receive_data;
                        act_good = receive_frame_good;
                    end
                    @(posedge clock);
                    #1;
                    receive_data_enable = (($random(seed) & 3) != 0);
                    waited++;
                end
                if (!got) begin
                    $display("Timeout: byte %0d of frame %0d never arrived at the output", i, f);
                    err_other++;
                    aborted = 1'b1;
                end else begin
                    check_word(f, i, exp, act);
                    if (exp.last) begin
                        check_good(f, frame_good[f], act_good);
                    end
                end
            end
        end
    endtask

    task automatic finish_run();
        int total;
        total = err_data + err_good + err_valid + err_other;
        $display("Errors: data %0d, good %0d, valid %0d, other %0d",
                 err_data, err_good, err_valid, err_other);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        rst_n                    = 1'b0;
        rmii_receive_data        = '0;
        rmii_receive_data_enable = 1'b0;
        rmii_receive_data_error  = 1'b0;
        receive_data_enable      = 1'b0;
        err_data                 = 0;
        err_good                 = 0;
        err_valid                = 0;
        err_other                = 0;
        first_data_sent          = 1'b0;
        aborted                  = 1'b0;
        load_stimulus();
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;
        fork
            drive_frames();
            monitor_frames();
        join
        // No extra word after the last frame
        if (!aborted) begin
            receive_data_enable = 1'b1;
            repeat (40) begin
                @(negedge clock);
                check_idle(receive_data_valid, "after the last frame");
            end
        end
        finish_run();
    end

endmodule

// ==== list.f ====
verilog/rmii_rx_pkg.sv
verilog/rmii_rx_deserializer.sv
verilog/frame_fifo.sv
verilog/frame_checker.sv
verilog/rmii_rx_port.sv
dv/rmii_rx_port_sva.sv
dv/rmii_rx_port_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the RMII receive port testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f list.f \
    --top-module rmii_rx_port_tb \
    -o rmii_rx_sim

./obj_dir/rmii_rx_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi

// ==== dv/rmii_rx_stimulus.txt ====
# err_byte (ff = none), stray dibit, expected good, idle cycles after frame,
# then the frame bytes in hex, FCS included, all on one line per frame
ff 0 1 0a 31 32 33 34 35 36 37 38 39 26 39 f4 cb
ff 0 1 03 61 62 63 c2 41 24 35
ff 1 1 02 61 43 be b7 e8
# one data byte corrupted, FCS left as it was
ff 0 0 04 31 32 33 34 75 36 37 38 39 26 39 f4 cb
# error input raised during byte 3 of a frame with a matching FCS
03 0 0 02 68 65 6c 6c 6f 20 77 6f 72 6c 64 85 11 4a 0d
ff 0 1 01 6d 65 73 73 61 67 65 20 64 69 67 65 73 74 7f 9d 15 20
ff 1 0 03 61 62 63 c2 41 24 36
04 0 0 02 61 43 be b7 e8
ff 1 1 05 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70 71 72 73 74 75 76 77 78 79 7a bd 50 27 4c
ff 0 1 02 68 65 6c 6c 6f 20 77 6f 72 6c 64 85 11 4a 0d
00 1 0 02 31 32 33 34 35 36 37 38 39 26 39 f4 cb
ff 0 1 0c 31 32 33 34 35 36 37 38 39 26 39 f4 cb
